// File: bench/drone_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module drone_ctrl_chk #(
	parameter int frame_us = 2500
) (
	input logic sys_clk,
	input logic rst_n,
	input logic us_tick,
	input logic imu_valid,
	input logic ctrl_done,
	input logic [3:0] motor_pwm // Motor 1 in bit 0
);
	import drone_pkg::*;

	int assert_fails = 0; // Count of failed properties
	logic seen_done; // First control update made
	logic seen_rise; // One frame start already seen
	logic pwm1_q;
	logic [15:0] period_us; // Microseconds since motor 1 last rose
	logic [15:0] high_us [4]; // Pulse width so far

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			seen_done <= 1'b0;
			seen_rise <= 1'b0;
			pwm1_q <= 1'b0;
			period_us <= '0;
		end else begin
			pwm1_q <= motor_pwm[0];
			if (ctrl_done)
				seen_done <= 1'b1;
			if (motor_pwm[0] && !pwm1_q) begin
				seen_rise <= 1'b1;
				period_us <= 16'(us_tick); // Frame start counts as first us
			end else if (us_tick)
				period_us <= period_us + 1'b1;
		end
	end

	a_idle_low: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!seen_done |-> motor_pwm == 4'b0000)
		else begin
			$error("motor output high before the first control update");
			assert_fails++;
		end

	a_done_after: assert property (@(posedge sys_clk) disable iff (!rst_n)
		imu_valid |-> ##2 ctrl_done)
		else begin
			$error("ctrl_done missing two cycles after imu_valid");
			assert_fails++;
		end

	a_done_cause: assert property (@(posedge sys_clk) disable iff (!rst_n)
		ctrl_done |-> $past(imu_valid, 2))
		else begin
			$error("ctrl_done without imu_valid two cycles earlier");
			assert_fails++;
		end

	a_frame_period: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$rose(motor_pwm[0]) && seen_rise |-> period_us == 16'(frame_us))
		else begin
			$error("motor pulses not spaced by one frame");
			assert_fails++;
		end

	for (genvar i = 0; i < 4; i++) begin : g_motor
		always_ff @(posedge sys_clk or negedge rst_n) begin
			if (!rst_n)
				high_us[i] <= '0;
			else if (!motor_pwm[i])
				high_us[i] <= '0;
			else if (us_tick)
				high_us[i] <= high_us[i] + 1'b1;
		end

		// ESC range is 1000..2000 us
		a_width: assert property (@(posedge sys_clk) disable iff (!rst_n)
			$fell(motor_pwm[i]) |-> high_us[i] >= 16'(pulse_min_us)
				&& high_us[i] <= 16'(pulse_min_us + pulse_span_us))
			else begin
				$error("motor %0d pulse width outside the ESC range", i + 1);
				assert_fails++;
			end
	end

endmodule

bind drone_ctrl drone_ctrl_chk #(.frame_us(frame_us)) i_chk (
	.sys_clk, .rst_n, .us_tick, .imu_valid, .ctrl_done,
	.motor_pwm({motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm})
);

`default_nettype wire

// File: bench/drone_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module drone_ctrl_tb;
	import drone_pkg::*;

	localparam int frame_us = 2500;
	localparam int kp_shift = 2;
	localparam int n_center = 3; // Centered sticks at three throttle settings
	localparam int n_random = 8;
	localparam int frames_per_test = 4; // Sticks, update, frame alignment, measured pulse
	localparam int idle_frames = 2; // Frame starts seen before any control update
	localparam int wd_cycles = ((n_center + n_random) * frames_per_test + idle_frames + 4)
		* frame_us;

	logic sys_clk;
	logic rst_n;
	logic throttle_pwm;
	logic yaw_pwm;
	logic roll_pwm;
	logic pitch_pwm;
	logic imu_valid;
	logic signed [imu_val_w-1:0] roll_actual;
	logic signed [imu_val_w-1:0] pitch_actual;
	logic [3:0] motor_pwm; // Motor 1 in bit 0
	logic ctrl_done;
	int exp_width [4]; // Predicted pulse widths in cycles
	int got_width [4];
	int tests_run;
	int tests_failed;

	drone_ctrl #(.clk_per_us(1), .frame_us(frame_us), .kp_shift(kp_shift)) i_dut (
		.sys_clk, .rst_n, .throttle_pwm, .yaw_pwm, .roll_pwm, .pitch_pwm, .imu_valid,
		.roll_actual, .pitch_actual, .motor_1_pwm(motor_pwm[0]), .motor_2_pwm(motor_pwm[1]),
		.motor_3_pwm(motor_pwm[2]), .motor_4_pwm(motor_pwm[3]), .ctrl_done);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk; // 4 ns, one us_tick per cycle here
	end

	// Stick value from a pulse width in microseconds
	function automatic int rc_value(input int width_us);
		int over;
		over = width_us - pulse_min_us;
		if (over < 0)
			over = 0;
		if (over > pulse_span_us)
			over = pulse_span_us;
		return over / 4;
	endfunction

	// Angle loop for one axis, 16 LSB per degree of stick
	function automatic int axis_rate(input int stick, input int angle);
		int err;
		err = (stick - stick_center) * 16 - angle;
		return err >>> kp_shift;
	endfunction

	function automatic int clamp_motor(input int sum);
		if (sum < 0)
			return 0;
		if (sum > motor_max)
			return motor_max;
		return sum;
	endfunction

	task automatic predict(input int w_thr, input int w_yaw, input int w_roll,
		input int w_pitch, input int r_ang, input int p_ang);
		int thr;
		int yaw;
		int roll;
		int pitch;
		thr = rc_value(w_thr) * 4;
		yaw = rc_value(w_yaw) - stick_center;
		roll = axis_rate(rc_value(w_roll), r_ang);
		pitch = axis_rate(rc_value(w_pitch), p_ang);
		exp_width[0] = pulse_min_us + clamp_motor(thr + pitch + roll - yaw); // Front left
		exp_width[1] = pulse_min_us + clamp_motor(thr + pitch - roll + yaw); // Front right
		exp_width[2] = pulse_min_us + clamp_motor(thr - pitch - roll - yaw); // Rear right
		exp_width[3] = pulse_min_us + clamp_motor(thr - pitch + roll + yaw); // Rear left
	endtask

	// All four RC pulses start together, each drops after its own width
	task automatic drive_sticks(input int w_thr, input int w_yaw, input int w_roll,
		input int w_pitch);
		{throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm} = 4'b1111;
		for (int t = 1; t <= 2100; t++) begin
			@(negedge sys_clk);
			if (t == w_thr)
				throttle_pwm = 1'b0;
			if (t == w_yaw)
				yaw_pwm = 1'b0;
			if (t == w_roll)
				roll_pwm = 1'b0;
			if (t == w_pitch)
				pitch_pwm = 1'b0;
		end
		repeat (4) @(negedge sys_clk); // Synchronizer and value register
	endtask

	task automatic run_case(input string name, input int w_thr, input int w_yaw,
		input int w_roll, input int w_pitch, input int r_ang, input int p_ang, input bit burst);
		int fails;
		fails = 0;
		drive_sticks(w_thr, w_yaw, w_roll, w_pitch);
		predict(w_thr, w_yaw, w_roll, w_pitch, r_ang, p_ang);
		if (burst) begin
			imu_valid = 1'b1; // Older sample, overwritten by the next strobe
			roll_actual = imu_val_w'(int'($urandom_range(8000)) - 4000);
			pitch_actual = imu_val_w'(int'($urandom_range(8000)) - 4000);
			@(negedge sys_clk);
		end
		imu_valid = 1'b1;
		roll_actual = imu_val_w'(r_ang);
		pitch_actual = imu_val_w'(p_ang);
		@(negedge sys_clk);
		imu_valid = 1'b0;
		while (!ctrl_done)
			@(negedge sys_clk);
		while (ctrl_done)
			@(negedge sys_clk); // Mix now holds the last strobe
		@(negedge sys_clk);
		while (motor_pwm[0])
			@(negedge sys_clk); // Skip a pulse framed with older rates
		while (!motor_pwm[0])
			@(negedge sys_clk);
		for (int i = 0; i < 4; i++)
			got_width[i] = 0;
		while (motor_pwm != 4'b0000) begin
			for (int i = 0; i < 4; i++)
				got_width[i] += int'(motor_pwm[i]);
			@(negedge sys_clk);
		end
		for (int i = 0; i < 4; i++) begin
			assert (got_width[i] == exp_width[i]) else begin
				$display("MISMATCH at %0t: %s motor %0d pulse %0d us, expected %0d us",
					$time, name, i + 1, got_width[i], exp_width[i]);
				fails++;
			end
		end
		tests_run++;
		if (fails != 0)
			tests_failed++;
		$display("%s: %s", name, (fails == 0) ? "ok" : "wrong pulse width");
	endtask

	initial begin
		int r_ang;
		int p_ang;
		void'($urandom(38)); // Fixed seed
		rst_n = 1'b0;
		{throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm} = 4'b0000;
		imu_valid = 1'b0;
		roll_actual = '0;
		pitch_actual = '0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(negedge sys_clk);
		rst_n = 1'b1;
		repeat (idle_frames * frame_us) @(negedge sys_clk); // Frame starts with no mix yet
		for (int k = 0; k < n_center; k++)
			run_case($sformatf("center_%0d", k), 1100 + 350 * k, 1500, 1500, 1500, 0, 0, 1'b0);
		for (int k = 0; k < n_random; k++) begin
			r_ang = int'($urandom_range(8000)) - 4000; // About 250 degrees either way
			p_ang = int'($urandom_range(8000)) - 4000;
			run_case($sformatf("random_%0d", k), $urandom_range(2100, 900),
				$urandom_range(2100, 900), $urandom_range(2100, 900),
				$urandom_range(2100, 900), r_ang, p_ang, (k % 2) == 1);
		end
		$display("Tests run %0d, failed %0d, checker assertion failures %0d",
			tests_run, tests_failed, i_dut.i_chk.assert_fails);
		if (tests_failed == 0 && i_dut.i_chk.assert_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (wd_cycles) @(posedge sys_clk);
		$display("Timeout: tests did not finish within %0d cycles", wd_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/drone_pkg.sv
verilog/us_tick_gen.sv
verilog/receiver.sv
verilog/angle_controller.sv
verilog/motor_mixer.sv
verilog/pwm_generator.sv
verilog/drone_ctrl.sv
bench/drone_ctrl_chk.sv
bench/drone_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module drone_ctrl_tb \
	-f flist.f -o drone_ctrl_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/drone_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "RESULT: PASS" sim.log && exit 0 || exit 1

// File: verilog/angle_controller.sv
`timescale 1ns/1ps
`default_nettype none

module angle_controller #(
	parameter int kp_shift = 2
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic start,
	input  logic [drone_pkg::rec_val_w-1:0] throttle_val,
	input  logic [drone_pkg::rec_val_w-1:0] yaw_val,
	input  logic [drone_pkg::rec_val_w-1:0] roll_val,
	input  logic [drone_pkg::rec_val_w-1:0] pitch_val,
	input  logic signed [drone_pkg::imu_val_w-1:0] roll_actual,
	input  logic signed [drone_pkg::imu_val_w-1:0] pitch_actual,
	output logic signed [drone_pkg::rate_w-1:0] throttle_rate,
	output logic signed [drone_pkg::rate_w-1:0] yaw_rate,
	output logic signed [drone_pkg::rate_w-1:0] roll_rate,
	output logic signed [drone_pkg::rate_w-1:0] pitch_rate,
	output logic done
);
	import drone_pkg::*;

	localparam int err_w = rate_w + 1; // Target minus angle can exceed rate_w

	logic [1:0] valid_sr; // Stage 1 and stage 2 occupancy
	logic signed [err_w-1:0] roll_err_q;
	logic signed [err_w-1:0] pitch_err_q;
	logic signed [rate_w-1:0] throttle_q;
	logic signed [rate_w-1:0] yaw_q;

	// Signed stick deflection, one step per degree
	function automatic logic signed [err_w-1:0] stick_offset(input logic [rec_val_w-1:0] v);
		return $signed(err_w'(v)) - $signed(err_w'(stick_center));
	endfunction

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[0], start}; // Accepts a start every cycle
	end

	// Stage 1: target angle in IMU units, then angle error
	always_ff @(posedge sys_clk) begin
		if (start) begin
			roll_err_q <= (stick_offset(roll_val) <<< 4) - err_w'(roll_actual);
			pitch_err_q <= (stick_offset(pitch_val) <<< 4) - err_w'(pitch_actual);
			yaw_q <= rate_w'(stick_offset(yaw_val)); // Yaw is rate command directly
			throttle_q <= rate_w'({throttle_val, 2'b00}); // Times 4 to motor scale
		end
	end

	// Stage 2: proportional gain as arithmetic shift
	always_ff @(posedge sys_clk) begin
		if (valid_sr[0]) begin
			roll_rate <= rate_w'(roll_err_q >>> kp_shift);
			pitch_rate <= rate_w'(pitch_err_q >>> kp_shift);
			yaw_rate <= yaw_q;
			throttle_rate <= throttle_q;
		end
	end

	assign done = valid_sr[1]; // Two cycles after start

endmodule

`default_nettype wire

// File: verilog/drone_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module drone_ctrl #(
	parameter int clk_per_us = 38,
	parameter int frame_us = 2500,
	parameter int kp_shift = 2
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic throttle_pwm,
	input  logic yaw_pwm,
	input  logic roll_pwm,
	input  logic pitch_pwm,
	input  logic imu_valid,
	input  logic signed [drone_pkg::imu_val_w-1:0] roll_actual,
	input  logic signed [drone_pkg::imu_val_w-1:0] pitch_actual,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm,
	output logic ctrl_done
);
	import drone_pkg::*;

	logic us_tick;
	logic [rec_val_w-1:0] throttle_val; // Receiver to angle loop
	logic [rec_val_w-1:0] yaw_val;
	logic [rec_val_w-1:0] roll_val;
	logic [rec_val_w-1:0] pitch_val;
	logic signed [rate_w-1:0] throttle_rate; // Angle loop to mixer
	logic signed [rate_w-1:0] yaw_rate;
	logic signed [rate_w-1:0] roll_rate;
	logic signed [rate_w-1:0] pitch_rate;
	logic ac_done;
	logic [motor_rate_w-1:0] motor_1_rate; // Mixer to PWM
	logic [motor_rate_w-1:0] motor_2_rate;
	logic [motor_rate_w-1:0] motor_3_rate;
	logic [motor_rate_w-1:0] motor_4_rate;
	logic mix_valid;

	us_tick_gen #(.clk_per_us(clk_per_us)) i_us_tick_gen (.sys_clk, .rst_n, .us_tick);

	receiver i_receiver (.sys_clk, .rst_n, .us_tick, .throttle_pwm, .yaw_pwm, .roll_pwm,
		.pitch_pwm, .throttle_val, .yaw_val, .roll_val, .pitch_val);

	angle_controller #(.kp_shift(kp_shift)) i_angle_controller (.sys_clk, .rst_n,
		.start(imu_valid), .throttle_val, .yaw_val, .roll_val, .pitch_val, .roll_actual,
		.pitch_actual, .throttle_rate, .yaw_rate, .roll_rate, .pitch_rate, .done(ac_done));

	motor_mixer i_motor_mixer (.sys_clk, .rst_n, .load(ac_done), .throttle_rate, .yaw_rate,
		.roll_rate, .pitch_rate, .motor_1_rate, .motor_2_rate, .motor_3_rate, .motor_4_rate,
		.mix_valid);

	pwm_generator #(.frame_us(frame_us)) i_pwm_generator (.sys_clk, .rst_n, .us_tick,
		.enable(mix_valid), .motor_1_rate, .motor_2_rate, .motor_3_rate, .motor_4_rate,
		.motor_1_pwm, .motor_2_pwm, .motor_3_pwm, .motor_4_pwm);

	assign ctrl_done = ac_done; // Angle loop strobe exported

endmodule

`default_nettype wire

// File: verilog/drone_pkg.sv
`default_nettype none

package drone_pkg;

	// Stick value from the RC receiver, 0..250
	localparam int rec_val_w = 8;

	// Signed target rates between angle loop and mixer
	localparam int rate_w = 16;

	// Attitude angles, 16 LSB per degree
	localparam int imu_val_w = 16;

	// Motor rate into the ESC pulse generator
	localparam int motor_rate_w = 10;

	// Standard RC/ESC pulse is 1000..2000 us
	localparam int pulse_min_us = 1000; // Zero throttle pulse width
	localparam int pulse_span_us = 1000; // Full scale above the base

	// Motor rate ceiling, maps to a 2000 us pulse
	localparam int motor_max = 1000;

	// Stick value seen with the stick at rest
	// (1500 us pulse gives 500 / 4)
	localparam int stick_center = 125;

endpackage

`default_nettype wire

// File: verilog/motor_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module motor_mixer (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic load,
	input  logic signed [drone_pkg::rate_w-1:0] throttle_rate,
	input  logic signed [drone_pkg::rate_w-1:0] yaw_rate,
	input  logic signed [drone_pkg::rate_w-1:0] roll_rate,
	input  logic signed [drone_pkg::rate_w-1:0] pitch_rate,
	output logic [drone_pkg::motor_rate_w-1:0] motor_1_rate,
	output logic [drone_pkg::motor_rate_w-1:0] motor_2_rate,
	output logic [drone_pkg::motor_rate_w-1:0] motor_3_rate,
	output logic [drone_pkg::motor_rate_w-1:0] motor_4_rate,
	output logic mix_valid
);
	import drone_pkg::*;

	localparam int sum_w = rate_w + 2; // Four-term sum without overflow

	logic signed [sum_w-1:0] thr_w; // Sign-extended operands
	logic signed [sum_w-1:0] yaw_w;
	logic signed [sum_w-1:0] roll_w;
	logic signed [sum_w-1:0] pitch_w;
	logic signed [sum_w-1:0] sum_1;
	logic signed [sum_w-1:0] sum_2;
	logic signed [sum_w-1:0] sum_3;
	logic signed [sum_w-1:0] sum_4;

	function automatic logic [motor_rate_w-1:0] clamp(input logic signed [sum_w-1:0] s);
		if (s < 0)
			return '0; // Motor cannot spin backwards
		if (s > $signed(sum_w'(motor_max)))
			return motor_rate_w'(motor_max);
		return motor_rate_w'(s);
	endfunction

	assign thr_w = sum_w'(throttle_rate);
	assign yaw_w = sum_w'(yaw_rate);
	assign roll_w = sum_w'(roll_rate);
	assign pitch_w = sum_w'(pitch_rate);

	// X frame, props 1 and 3 share spin direction
	assign sum_1 = thr_w + pitch_w + roll_w - yaw_w; // Front left
	assign sum_2 = thr_w + pitch_w - roll_w + yaw_w; // Front right
	assign sum_3 = thr_w - pitch_w - roll_w - yaw_w; // Rear right
	assign sum_4 = thr_w - pitch_w + roll_w + yaw_w; // Rear left

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			mix_valid <= 1'b0;
		else if (load)
			mix_valid <= 1'b1; // Sticky after first mix
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			motor_1_rate <= clamp(sum_1);
			motor_2_rate <= clamp(sum_2);
			motor_3_rate <= clamp(sum_3);
			motor_4_rate <= clamp(sum_4);
		end
	end

endmodule

`default_nettype wire

// File: verilog/pwm_generator.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_generator #(
	parameter int frame_us = 2500
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic us_tick,
	input  logic enable,
	input  logic [drone_pkg::motor_rate_w-1:0] motor_1_rate,
	input  logic [drone_pkg::motor_rate_w-1:0] motor_2_rate,
	input  logic [drone_pkg::motor_rate_w-1:0] motor_3_rate,
	input  logic [drone_pkg::motor_rate_w-1:0] motor_4_rate,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm
);
	import drone_pkg::*;

	localparam int cnt_w = $clog2(frame_us + pulse_min_us + motor_max); // Fits frame and limit

	logic [cnt_w-1:0] frame_cnt; // Microseconds into the frame
	logic frame_start;
	logic active; // Rates valid for this frame
	logic [motor_rate_w-1:0] rate_in [4];
	logic [motor_rate_w-1:0] rate_q [4]; // Rates frozen for the frame
	logic [3:0] pwm_q;

	assign rate_in[0] = motor_1_rate;
	assign rate_in[1] = motor_2_rate;
	assign rate_in[2] = motor_3_rate;
	assign rate_in[3] = motor_4_rate;
	assign frame_start = us_tick && (frame_cnt == cnt_w'(frame_us - 1));

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
			active <= 1'b0;
			pwm_q <= '0;
		end else begin
			if (us_tick)
				frame_cnt <= frame_start ? '0 : frame_cnt + 1'b1;
			if (frame_start)
				active <= enable; // Only arm at a frame boundary
			for (int i = 0; i < 4; i++)
				pwm_q[i] <= active && (frame_cnt < cnt_w'(pulse_min_us) + cnt_w'(rate_q[i]));
		end
	end

	always_ff @(posedge sys_clk) begin
		if (frame_start)
			rate_q <= rate_in; // No mid-pulse change
	end

	// Registered outputs keep the ESC lines glitch free
	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

endmodule

`default_nettype wire

// File: verilog/receiver.sv
`timescale 1ns/1ps
`default_nettype none

module receiver (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic us_tick,
	input  logic throttle_pwm,
	input  logic yaw_pwm,
	input  logic roll_pwm,
	input  logic pitch_pwm,
	output logic [drone_pkg::rec_val_w-1:0] throttle_val,
	output logic [drone_pkg::rec_val_w-1:0] yaw_val,
	output logic [drone_pkg::rec_val_w-1:0] roll_val,
	output logic [drone_pkg::rec_val_w-1:0] pitch_val
);
	import drone_pkg::*;

	localparam int cnt_w = $clog2(pulse_min_us + pulse_span_us) + 1; // Headroom over 2000 us

	logic [3:0] pwm_in; // Channel order: throttle, yaw, roll, pitch
	logic [3:0] sync_1; // Metastability stage
	logic [3:0] sync_2; // Synchronized level
	logic [3:0] sync_3; // Previous level for edge detect
	logic [3:0] rise;
	logic [3:0] fall;
	logic [cnt_w-1:0] width_cnt [4]; // Pulse width in microseconds
	logic [rec_val_w-1:0] val_q [4]; // Held stick values

	// Width above the base, clamped to the span and scaled to 0..250
	function automatic logic [rec_val_w-1:0] scale(input logic [cnt_w-1:0] width);
		logic [cnt_w-1:0] over;
		if (width <= cnt_w'(pulse_min_us))
			over = '0; // Short pulse reads as zero stick
		else if (width >= cnt_w'(pulse_min_us + pulse_span_us))
			over = cnt_w'(pulse_span_us); // Long pulse saturates
		else
			over = width - cnt_w'(pulse_min_us);
		return rec_val_w'(over >> 2); // Divide by 4, truncate
	endfunction

	assign pwm_in = {pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};
	assign rise = sync_2 & ~sync_3;
	assign fall = ~sync_2 & sync_3;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_3 <= '0;
		end else begin
			sync_1 <= pwm_in;
			sync_2 <= sync_1;
			sync_3 <= sync_2;
		end
	end

	for (genvar ch = 0; ch < 4; ch++) begin : g_chan
		always_ff @(posedge sys_clk or negedge rst_n) begin
			if (!rst_n) begin
				width_cnt[ch] <= '0;
				val_q[ch] <= '0;
			end else begin
				if (rise[ch])
					width_cnt[ch] <= cnt_w'(us_tick); // Restart, first tick counts
				else if (sync_2[ch] && us_tick && width_cnt[ch] != '1)
					width_cnt[ch] <= width_cnt[ch] + 1'b1; // Saturates on a stuck-high input
				if (fall[ch])
					val_q[ch] <= scale(width_cnt[ch]); // Update once per pulse
			end
		end
	end

	assign throttle_val = val_q[0];
	assign yaw_val = val_q[1];
	assign roll_val = val_q[2];
	assign pitch_val = val_q[3];

endmodule

`default_nettype wire

// File: verilog/us_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module us_tick_gen #(
	parameter int clk_per_us = 38
) (
	input  logic sys_clk,
	input  logic rst_n,
	output logic us_tick
);

	localparam int cnt_w = $clog2(clk_per_us + 1); // At least one bit for clk_per_us of 1

	logic [cnt_w-1:0] div_cnt; // Cycles since the last tick

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			us_tick <= 1'b0;
		end else if (div_cnt == cnt_w'(clk_per_us - 1)) begin
			div_cnt <= '0; // Wrap every microsecond
			us_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			us_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire
